// ==== pcnt_pkg.sv ====
// shared constants and types for the performance counter block, imported by the RTL modules
package pcnt_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // event map
  ////////////////////////////////////////////////////////////////////////////

  localparam int N_STD_EVENTS = 11;  // built-in events, cycle counter included

  // counter index of each built-in event, external events follow from 11 up
  typedef enum logic [3:0] {
    EV_CYCLES       = 4'd0,   // free running, tied high in the gate
    EV_INSTR        = 4'd1,   // instruction retired
    EV_LD_STALL     = 4'd2,
    EV_JR_STALL     = 4'd3,
    EV_IMISS        = 4'd4,
    EV_LOAD         = 4'd5,
    EV_STORE        = 4'd6,
    EV_JUMP         = 4'd7,
    EV_BRANCH       = 4'd8,
    EV_BRANCH_TAKEN = 4'd9,
    EV_COMPRESSED   = 4'd10
  } pcnt_event_e;

  ////////////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////////////

  localparam int APB_ADDR_W   = 8;
  localparam int APB_DATA_W   = 32;
  localparam int MAX_COUNTERS = 32;  // counter window 0x00..0x7c, one word each

  localparam logic [APB_ADDR_W-1:0] PCER_OFFSET = 8'h80;  // enable mask
  localparam logic [APB_ADDR_W-1:0] PCMR_OFFSET = 8'h84;  // mode

  localparam int PCMR_EN_BIT  = 0;  // global enable
  localparam int PCMR_SAT_BIT = 1;  // saturate instead of wrap

  // what a bus address lands on
  typedef enum logic [1:0] {
    REG_COUNTER,
    REG_PCER,
    REG_PCMR,
    REG_NONE     // unaligned or unmapped, gives pslverr
  } pcnt_reg_e;

endpackage

// ==== pcnt_event_gate.sv ====
// samples the event pins once and masks them with PCER and the PCMR enable, one inc per counter
`timescale 1ns/1ps

module pcnt_event_gate
#(
  parameter int N_EXT_CNT = 2
)
(
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,

  // pipeline events, level sampled
  input  logic                                        evt_instr_i,
  input  logic                                        evt_ld_stall_i,
  input  logic                                        evt_jr_stall_i,
  input  logic                                        evt_imiss_i,
  input  logic                                        evt_load_i,
  input  logic                                        evt_store_i,
  input  logic                                        evt_jump_i,
  input  logic                                        evt_branch_i,
  input  logic                                        evt_branch_taken_i,
  input  logic                                        evt_compressed_i,
  input  logic [N_EXT_CNT-1:0]                        ext_evt_i,

  input  logic [pcnt_pkg::N_STD_EVENTS+N_EXT_CNT-1:0] pcer_i,     // per counter enable
  input  logic                                        pcmr_en_i,  // global enable
  output logic [pcnt_pkg::N_STD_EVENTS+N_EXT_CNT-1:0] inc_o
);

  import pcnt_pkg::*;

  localparam int N_CNT = N_STD_EVENTS + N_EXT_CNT;

  logic [N_CNT-1:0] evt_raw;  // pins packed in counter order
  logic [N_CNT-1:0] evt_q;    // one cycle later

  always_comb
  begin
    evt_raw[EV_CYCLES]             = 1'b1;  // counts every clock
    evt_raw[EV_INSTR]              = evt_instr_i;
    evt_raw[EV_LD_STALL]           = evt_ld_stall_i;
    evt_raw[EV_JR_STALL]           = evt_jr_stall_i;
    evt_raw[EV_IMISS]              = evt_imiss_i;
    evt_raw[EV_LOAD]               = evt_load_i;
    evt_raw[EV_STORE]              = evt_store_i;
    evt_raw[EV_JUMP]               = evt_jump_i;
    evt_raw[EV_BRANCH]             = evt_branch_i;
    evt_raw[EV_BRANCH_TAKEN]       = evt_branch_taken_i;
    evt_raw[EV_COMPRESSED]         = evt_compressed_i;
    evt_raw[N_CNT-1:N_STD_EVENTS]  = ext_evt_i;  // externals sit above the built-ins
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      evt_q <= '0;
    else
      evt_q <= evt_raw;
  end

  // masks applied in the cycle after sampling, not at the pin
  assign inc_o = evt_q & pcer_i & {N_CNT{pcmr_en_i}};

  // an increment needs its PCER bit and an event seen at the pin one cycle earlier
  a_inc_masked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (inc_o & ~(pcer_i & $past(evt_raw))) == '0)
    else $error("inc raised without PCER set or without a sampled event");

endmodule

// ==== pcnt_counter.sv ====
// one counter slice, loaded from the bus and bumped by its qualified event
`timescale 1ns/1ps

module pcnt_counter
#(
  parameter int CNT_WIDTH = 32
)
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  input  logic                 inc_i,      // qualified event
  input  logic                 wr_en_i,    // bus load, wins over inc
  input  logic                 sat_i,      // hold at all ones
  input  logic [CNT_WIDTH-1:0] wr_data_i,
  output logic [CNT_WIDTH-1:0] count_o
);

  logic [CNT_WIDTH-1:0] count_q;
  logic [CNT_WIDTH-1:0] count_d;
  logic                 at_max;

  assign at_max = &count_q;

  always_comb
  begin
    count_d = count_q;
    if (wr_en_i)
      count_d = wr_data_i;
    else if (inc_i && !(at_max && sat_i))
      count_d = count_q + 1'b1;  // rolls to zero at all ones
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      count_q <= '0;
    else
      count_q <= count_d;
  end

  assign count_o = count_q;

  // next count is held, +1, wrapped to zero or the loaded word, nothing else
  property p_next_value;
    @(posedge clk_i) disable iff (!rst_n_i)
    1'b1 |=> ($past(wr_en_i) && count_q == $past(wr_data_i))
          || (count_q == $past(count_q))
          || (!$past(at_max) && count_q == CNT_WIDTH'($past(count_q) + 1'b1))
          || ($past(at_max) && !$past(sat_i) && count_q == '0);
  endproperty

  a_next_value: assert property (p_next_value)
    else $error("counter took an illegal step");

endmodule

// ==== pcnt_apb_regs.sv ====
// zero wait state APB slave holding PCER and PCMR, loading counters and reading them back
`timescale 1ns/1ps

module pcnt_apb_regs
#(
  parameter int N_EXT_CNT = 2,
  parameter int CNT_WIDTH = 32
)
(
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,

  // APB slave
  input  logic                                        psel_i,
  input  logic                                        penable_i,
  input  logic                                        pwrite_i,
  input  logic [pcnt_pkg::APB_ADDR_W-1:0]             paddr_i,
  input  logic [pcnt_pkg::APB_DATA_W-1:0]             pwdata_i,
  output logic [pcnt_pkg::APB_DATA_W-1:0]             prdata_o,
  output logic                                        pready_o,
  output logic                                        pslverr_o,

  // counter bank
  input  logic [pcnt_pkg::N_STD_EVENTS+N_EXT_CNT-1:0]
               [CNT_WIDTH-1:0]                        count_i,
  output logic [pcnt_pkg::N_STD_EVENTS+N_EXT_CNT-1:0] pcer_o,
  output logic                                        pcmr_en_o,
  output logic                                        pcmr_sat_o,
  output logic [pcnt_pkg::N_STD_EVENTS+N_EXT_CNT-1:0] cnt_wr_en_o,   // one-hot load
  output logic [CNT_WIDTH-1:0]                        cnt_wr_data_o
);

  import pcnt_pkg::*;

  localparam int N_CNT = N_STD_EVENTS + N_EXT_CNT;
  localparam int IDX_W = $clog2(MAX_COUNTERS);  // word index inside the counter window

  logic             apb_access;  // second phase of a transfer
  logic             reg_wr;      // write that is allowed to land
  pcnt_reg_e        reg_kind;
  logic [IDX_W-1:0] cnt_idx;
  logic [N_CNT-1:0] pcer_q;
  logic             pcmr_en_q;
  logic             pcmr_sat_q;
  logic [CNT_WIDTH-1:0] cnt_rd;  // selected counter

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  assign cnt_idx = paddr_i[IDX_W+1:2];

  always_comb
  begin
    reg_kind = REG_NONE;
    if (paddr_i[1:0] == 2'b00)  // word aligned only
    begin
      if (paddr_i[APB_ADDR_W-1:IDX_W+2] == '0)  // inside 0x00..0x7c
      begin
        if (cnt_idx < N_CNT)
          reg_kind = REG_COUNTER;  // upper part of the window is unpopulated
      end
      else if (paddr_i == PCER_OFFSET)
        reg_kind = REG_PCER;
      else if (paddr_i == PCMR_OFFSET)
        reg_kind = REG_PCMR;
    end
  end

  assign apb_access = psel_i & penable_i;
  assign reg_wr     = apb_access & pwrite_i & (reg_kind != REG_NONE);

  assign pready_o  = apb_access;                          // never stretched
  assign pslverr_o = apb_access & (reg_kind == REG_NONE);

  ////////////////////////////////////////////////////////////////////////////
  // control registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      pcer_q     <= '0;    // all counters masked
      pcmr_en_q  <= 1'b1;
      pcmr_sat_q <= 1'b1;
    end
    else if (reg_wr)
    begin
      if (reg_kind == REG_PCER)
        pcer_q <= pwdata_i[N_CNT-1:0];  // bits of absent counters dropped
      if (reg_kind == REG_PCMR)
      begin
        pcmr_en_q  <= pwdata_i[PCMR_EN_BIT];
        pcmr_sat_q <= pwdata_i[PCMR_SAT_BIT];
      end
    end
  end

  assign pcer_o     = pcer_q;
  assign pcmr_en_o  = pcmr_en_q;
  assign pcmr_sat_o = pcmr_sat_q;

  // counter load, lands at the edge ending the access cycle
  always_comb
  begin
    for (int i = 0; i < N_CNT; i++)
      cnt_wr_en_o[i] = reg_wr && (reg_kind == REG_COUNTER) && (cnt_idx == IDX_W'(i));
  end

  assign cnt_wr_data_o = pwdata_i[CNT_WIDTH-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // read back
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    cnt_rd = '0;
    for (int i = 0; i < N_CNT; i++)
      if (cnt_idx == IDX_W'(i))
        cnt_rd = count_i[i];
  end

  always_comb
  begin
    prdata_o = '0;  // also what an erroring read returns
    if (psel_i && !pwrite_i)
    begin
      case (reg_kind)
        REG_COUNTER: prdata_o[CNT_WIDTH-1:0] = cnt_rd;  // zero extended
        REG_PCER:    prdata_o[N_CNT-1:0]     = pcer_q;
        REG_PCMR:
        begin
          prdata_o[PCMR_EN_BIT]  = pcmr_en_q;
          prdata_o[PCMR_SAT_BIT] = pcmr_sat_q;
        end
        default:     prdata_o = '0;
      endcase
    end
  end

  // access phase only ever follows a selected setup phase
  a_penable_psel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    penable_i |-> psel_i)
    else $error("penable without psel");

  // a load is a single bit, set by an aligned write access to that counter's word
  a_load_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cnt_wr_en_o != '0) |->
      psel_i && penable_i && pwrite_i && (paddr_i[1:0] == 2'b00)
      && (cnt_wr_en_o == (N_CNT'(1) << paddr_i[APB_ADDR_W-1:2])))
    else $error("counter load does not match the addressed counter");

endmodule

// ==== pcnt_top.sv ====
// performance counter peripheral, event gate into the counter bank, read and loaded over APB
`timescale 1ns/1ps

module pcnt_top
#(
  parameter int N_EXT_CNT = 2,   // external events, at most 21
  parameter int CNT_WIDTH = 32
)
(
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  // event pins, one count per high cycle
  input  logic                            evt_instr_i,
  input  logic                            evt_ld_stall_i,
  input  logic                            evt_jr_stall_i,
  input  logic                            evt_imiss_i,
  input  logic                            evt_load_i,
  input  logic                            evt_store_i,
  input  logic                            evt_jump_i,
  input  logic                            evt_branch_i,
  input  logic                            evt_branch_taken_i,
  input  logic                            evt_compressed_i,
  input  logic [N_EXT_CNT-1:0]            ext_evt_i,

  // APB slave
  input  logic                            psel_i,
  input  logic                            penable_i,
  input  logic                            pwrite_i,
  input  logic [pcnt_pkg::APB_ADDR_W-1:0] paddr_i,
  input  logic [pcnt_pkg::APB_DATA_W-1:0] pwdata_i,
  output logic [pcnt_pkg::APB_DATA_W-1:0] prdata_o,
  output logic                            pready_o,
  output logic                            pslverr_o
);

  import pcnt_pkg::*;

  localparam int N_CNT = N_STD_EVENTS + N_EXT_CNT;

  logic [N_CNT-1:0]                inc;          // gate -> counters
  logic [N_CNT-1:0]                pcer;
  logic                            pcmr_en;
  logic                            pcmr_sat;
  logic [N_CNT-1:0]                cnt_wr_en;    // regs -> counters
  logic [CNT_WIDTH-1:0]            cnt_wr_data;
  logic [N_CNT-1:0][CNT_WIDTH-1:0] count;        // counters -> regs

  ////////////////////////////////////////////////////////////////////////////
  // event gate
  ////////////////////////////////////////////////////////////////////////////

  pcnt_event_gate
  #(
    .N_EXT_CNT          ( N_EXT_CNT          )
  )
  u_gate
  (
    .clk_i              ( clk_i              ),
    .rst_n_i            ( rst_n_i            ),
    .evt_instr_i        ( evt_instr_i        ),
    .evt_ld_stall_i     ( evt_ld_stall_i     ),
    .evt_jr_stall_i     ( evt_jr_stall_i     ),
    .evt_imiss_i        ( evt_imiss_i        ),
    .evt_load_i         ( evt_load_i         ),
    .evt_store_i        ( evt_store_i        ),
    .evt_jump_i         ( evt_jump_i         ),
    .evt_branch_i       ( evt_branch_i       ),
    .evt_branch_taken_i ( evt_branch_taken_i ),
    .evt_compressed_i   ( evt_compressed_i   ),
    .ext_evt_i          ( ext_evt_i          ),
    .pcer_i             ( pcer               ),
    .pcmr_en_i          ( pcmr_en            ),
    .inc_o              ( inc                )
  );

  ////////////////////////////////////////////////////////////////////////////
  // counter bank
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < N_CNT; i++)
  begin : g_cnt
    pcnt_counter
    #(
      .CNT_WIDTH ( CNT_WIDTH    )
    )
    u_cnt
    (
      .clk_i     ( clk_i        ),
      .rst_n_i   ( rst_n_i      ),
      .inc_i     ( inc[i]       ),
      .wr_en_i   ( cnt_wr_en[i] ),
      .sat_i     ( pcmr_sat     ),  // shared mode bit
      .wr_data_i ( cnt_wr_data  ),
      .count_o   ( count[i]     )
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus side
  ////////////////////////////////////////////////////////////////////////////

  pcnt_apb_regs
  #(
    .N_EXT_CNT     ( N_EXT_CNT   ),
    .CNT_WIDTH     ( CNT_WIDTH   )
  )
  u_regs
  (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .psel_i        ( psel_i      ),
    .penable_i     ( penable_i   ),
    .pwrite_i      ( pwrite_i    ),
    .paddr_i       ( paddr_i     ),
    .pwdata_i      ( pwdata_i    ),
    .prdata_o      ( prdata_o    ),
    .pready_o      ( pready_o    ),
    .pslverr_o     ( pslverr_o   ),
    .count_i       ( count       ),
    .pcer_o        ( pcer        ),
    .pcmr_en_o     ( pcmr_en     ),
    .pcmr_sat_o    ( pcmr_sat    ),
    .cnt_wr_en_o   ( cnt_wr_en   ),
    .cnt_wr_data_o ( cnt_wr_data )
  );

endmodule

// ==== tb_pcnt.sv ====
// self-checking testbench for pcnt_top, built and run through verilog.f and the Makefile
`timescale 1ns/1ps

module tb_pcnt;

  localparam int N_EXT      = 2;
  localparam int N_CNT      = 11 + N_EXT;  // built-in events plus externals
  localparam int CLK_HALF   = 2;           // 4 ns period
  localparam int MAX_CYCLES = 4000;        // tests take well under half of this
  localparam logic [7:0] PCER_ADDR = 8'h80;
  localparam logic [7:0] PCMR_ADDR = 8'h84;
  localparam logic [7:0] LOAD_ADDR = 8'h14;  // counter 5, load events

  logic             clk;
  logic             rst_n;
  logic [N_CNT-1:0] evt;        // bit i feeds counter i, bit 0 unused
  logic             psel;
  logic             penable;
  logic             pwrite;
  logic [7:0]       paddr;
  logic [31:0]      pwdata;
  logic [31:0]      prdata;
  logic             pready;
  logic             pslverr;

  logic [15:0]      lfsr_q;
  logic [31:0]      ref_cnt [N_CNT];  // expected count per event
  logic [31:0]      snap [N_CNT];
  logic [N_CNT-1:0] pcer_sh;          // what PCER should hold
  logic             pcmr_en_sh;
  int               n_val_err   = 0;
  int               n_proto_err = 0;
  int               cycles      = 0;

  // unaligned, counters 13 and 31, above PCMR
  logic [7:0] bad_addr [6] = '{8'h06, 8'h81, 8'h34, 8'h7c, 8'h88, 8'hfc};

  pcnt_top
  #(
    .N_EXT_CNT          ( N_EXT       ),
    .CNT_WIDTH          ( 32          )
  )
  u_dut
  (
    .clk_i              ( clk         ),
    .rst_n_i            ( rst_n       ),
    .evt_instr_i        ( evt[1]      ),
    .evt_ld_stall_i     ( evt[2]      ),
    .evt_jr_stall_i     ( evt[3]      ),
    .evt_imiss_i        ( evt[4]      ),
    .evt_load_i         ( evt[5]      ),
    .evt_store_i        ( evt[6]      ),
    .evt_jump_i         ( evt[7]      ),
    .evt_branch_i       ( evt[8]      ),
    .evt_branch_taken_i ( evt[9]      ),
    .evt_compressed_i   ( evt[10]     ),
    .ext_evt_i          ( evt[12:11]  ),
    .psel_i             ( psel        ),
    .penable_i          ( penable     ),
    .pwrite_i           ( pwrite      ),
    .paddr_i            ( paddr       ),
    .pwdata_i           ( pwdata      ),
    .prdata_o           ( prdata      ),
    .pready_o           ( pready      ),
    .pslverr_o          ( pslverr     )
  );

  initial
  begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout, tests still running after %0d cycles", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus protocol checks
  ////////////////////////////////////////////////////////////////////////////

  a_quiet_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !(psel && penable) |-> (!pready && !pslverr))
    else
    begin
      n_proto_err++;
      $display("Fail %0d ns: pready or pslverr high outside an access cycle", $time);
    end

  a_no_wait: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable) |-> pready)
    else
    begin
      n_proto_err++;
      $display("Fail %0d ns: pready low in an access cycle", $time);
    end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_step(lfsr_q);  // one step per bit
      v[i]   = lfsr_q[0];
    end
    return v;
  endfunction

  task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      n_val_err++;
      $display("Fail %0d ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB transfers, entered and left 1 ns after a rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    psel    = 1'b1;  // setup
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;  // access
    @(negedge clk);
    rdata   = prdata;  // mid access cycle
    err     = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    bus_xfer(1'b1, addr, data, rd, err);
    expect_eq($sformatf("pslverr on write to %h", addr), 32'(err), 32'd0);
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] rd;
    logic        err;
    bus_xfer(1'b0, addr, 32'd0, rd, err);
    expect_eq($sformatf("pslverr on read of %h", addr), 32'(err), 32'd0);
    expect_eq(what, rd, exp);
  endtask

  // random levels on every event pin, reference follows PCER and PCMR
  task automatic drive_events(input int n);
    logic [N_CNT-1:0] pins;
    repeat (n)
    begin
      pins = N_CNT'(rand_bits(N_CNT - 1) << 1);
      evt  = pins;
      for (int i = 1; i < N_CNT; i++)
        if (pins[i] && pcer_sh[i] && pcmr_en_sh)
          ref_cnt[i] = ref_cnt[i] + 1;
      @(posedge clk);
      #1;
    end
    evt = '0;
    wait_cycles(3);  // two stages to drain
  endtask

  task automatic pulse_pin(input int idx, input int n);
    evt[idx] = 1'b1;
    wait_cycles(n);
    evt[idx] = 1'b0;
    wait_cycles(3);
  endtask

  initial
  begin
    logic [31:0] rdata;
    logic [31:0] first;
    logic [31:0] wdata;
    logic        err;

    rst_n      = 1'b0;
    evt        = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    lfsr_q     = 16'd59165;
    pcer_sh    = '0;
    pcmr_en_sh = 1'b1;
    for (int i = 0; i < N_CNT; i++)
      ref_cnt[i] = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // reset values
    for (int i = 0; i < N_CNT; i++)
      read_expect(8'(4 * i), 32'd0, $sformatf("counter %0d after reset", i));
    read_expect(PCER_ADDR, 32'd0, "PCER after reset");
    read_expect(PCMR_ADDR, 32'd3, "PCMR after reset");

    // random mask, cycle counter kept on for the step check
    pcer_sh = N_CNT'(rand_bits(N_CNT)) | N_CNT'(1);
    write_ok(PCER_ADDR, 32'(pcer_sh));
    drive_events(200);
    for (int i = 1; i < N_CNT; i++)
      read_expect(8'(4 * i), ref_cnt[i], $sformatf("counter %0d after masked run", i));

    // access cycles of back to back reads are two clocks apart
    bus_xfer(1'b0, 8'h00, 32'd0, first, err);
    bus_xfer(1'b0, 8'h00, 32'd0, rdata, err);
    expect_eq("cycle counter step", rdata - first, 32'd2);

    // global disable freezes every counter
    pcmr_en_sh = 1'b0;
    write_ok(PCMR_ADDR, 32'h2);
    wait_cycles(3);
    for (int i = 0; i < N_CNT; i++)
      bus_xfer(1'b0, 8'(4 * i), 32'd0, snap[i], err);
    drive_events(50);
    for (int i = 0; i < N_CNT; i++)
      read_expect(8'(4 * i), snap[i], $sformatf("counter %0d while disabled", i));
    pcmr_en_sh = 1'b1;
    write_ok(PCMR_ADDR, 32'h3);
    read_expect(PCMR_ADDR, 32'd3, "PCMR restored");

    ////////////////////////////////////////////////////////////////////////////
    // load and saturate on counter 5
    ////////////////////////////////////////////////////////////////////////////

    pcer_sh = '1;
    write_ok(PCER_ADDR, 32'(pcer_sh));
    wdata    = rand_bits(31);  // never all ones
    evt[5]   = 1'b1;           // held through setup and access
    write_ok(LOAD_ADDR, wdata);
    evt[5]   = 1'b0;
    wait_cycles(3);
    // load wins its edge, the pin level of the access cycle adds one after it
    read_expect(LOAD_ADDR, wdata + 32'd1, "load under event");

    write_ok(LOAD_ADDR, 32'hffff_fffe);
    pulse_pin(5, 3);
    read_expect(LOAD_ADDR, 32'hffff_ffff, "saturated counter");

    write_ok(PCMR_ADDR, 32'h1);  // saturate off
    write_ok(LOAD_ADDR, 32'hffff_fffe);
    pulse_pin(5, 3);
    read_expect(LOAD_ADDR, 32'h0000_0001, "wrapped counter");
    write_ok(PCMR_ADDR, 32'h3);

    // bus errors, zero write data would clear PCER/PCMR on a false decode
    for (int i = 0; i < 6; i++)
    begin
      bus_xfer(1'b0, bad_addr[i], 32'd0, rdata, err);
      expect_eq($sformatf("pslverr on read of %h", bad_addr[i]), 32'(err), 32'd1);
      expect_eq($sformatf("data on bad read of %h", bad_addr[i]), rdata, 32'd0);
      bus_xfer(1'b1, bad_addr[i], 32'd0, rdata, err);
      expect_eq($sformatf("pslverr on write to %h", bad_addr[i]), 32'(err), 32'd1);
    end
    read_expect(PCER_ADDR, 32'(pcer_sh), "PCER after bad writes");
    read_expect(PCMR_ADDR, 32'd3, "PCMR after bad writes");

    $display("errors: %0d value, %0d protocol", n_val_err, n_proto_err);
    if (n_val_err == 0 && n_proto_err == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
pcnt_pkg.sv
pcnt_event_gate.sv
pcnt_counter.sv
pcnt_apb_regs.sv
pcnt_top.sv
tb_pcnt.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_pcnt
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
